// ==== bench/ccu_mem_model.sv ====
// Behavioural word memory on the CCU external bus, acknowledging each beat after a random delay

`default_nettype none
`timescale 1ns/10ps

`include "ccu_params.svh"

module ccu_mem_model #(
    parameter int          WORDS    = 256,
    parameter logic [31:0] FILL_XOR = 32'h0,
    parameter logic [31:0] SEED     = 32'h6262942b
) (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_bus_req,
    input  logic                        i_bus_we,
    input  ccu_pkg::ccu_addr_t          i_bus_addr,
    input  logic [`CCU_BUS_WIDTH-1:0]   i_bus_wdata,
    input  ccu_pkg::ccu_len_t           i_bus_size,
    output logic                        o_bus_ack,
    output logic [`CCU_BUS_WIDTH-1:0]   o_bus_rdata
);

    localparam int IDX_WIDTH = $clog2(WORDS);

    logic [31:0]            mem [0:WORDS-1];
    logic [31:0]            rng_r;
    logic [31:0]            rng_next;
    logic [1:0]             wait_r;
    logic                   accept;
    logic [IDX_WIDTH-1:0]   idx;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte and halfword writes take their lanes from the matching lanes of the bus word
    function automatic logic [31:0] write_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [1:0] offset,
                                                input ccu_pkg::ccu_len_t size);
        logic [31:0] word;
        word = old;
        case (size)
            ccu_pkg::CCU_LEN_BYTE: word[offset*8 +: 8] = data[offset*8 +: 8];
            ccu_pkg::CCU_LEN_HALF: word[offset[1]*16 +: 16] = data[offset[1]*16 +: 16];
            default:               word = data;
        endcase
        return word;
    endfunction

    // Each word starts as its word address mixed with a constant
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = FILL_XOR ^ 32'(i);
        end
    end

    assign idx      = i_bus_addr[IDX_WIDTH+1:2];
    assign rng_next = xorshift32(rng_r);
    // A beat is taken once its idle cycles have run out, never in the ack cycle itself
    assign accept   = i_bus_req && !o_bus_ack && (wait_r == 2'd0);

    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_bus_ack   <= 1'b0;
            o_bus_rdata <= '0;
            rng_r       <= SEED;
            wait_r      <= SEED[1:0];
        end else if (o_bus_ack) begin
            o_bus_ack <= 1'b0;
            rng_r     <= rng_next;
            wait_r    <= rng_next[1:0];
        end else if (accept) begin
            o_bus_ack   <= 1'b1;
            o_bus_rdata <= mem[idx];
        end else if (i_bus_req) begin
            wait_r <= wait_r - 2'd1;
        end
    end

    always @(posedge i_clk) begin
        if (i_arst_n && accept && i_bus_we) begin
            mem[idx] = write_lanes(mem[idx], i_bus_wdata, i_bus_addr[1:0], i_bus_size);
        end
    end

endmodule

`default_nettype wire

// ==== bench/ccu_tb.sv ====
// Directed-test testbench for the CCU, run as the simulation top with the memory model on the bus

`default_nettype none
`timescale 1ns/10ps

`include "ccu_params.svh"

module ccu_tb;

    localparam int          MEM_WORDS = 256;
    localparam logic [31:0] FILL_XOR  = 32'hc3a5_96e1;
    localparam logic [31:0] SEED      = 32'h6262942b;
    localparam int          TIMEOUT   = 200;

    logic                       clk;
    logic                       arst_n;
    logic [`CCU_ARB_DEPTH-1:0]  req_valid;
    logic [`CCU_ARB_DEPTH-1:0]  req_we;
    ccu_pkg::ccu_len_t          req_len [0:`CCU_ARB_DEPTH-1];
    ccu_pkg::ccu_addr_t         req_addr [0:`CCU_ARB_DEPTH-1];
    ccu_pkg::ccu_line_t         req_wdata [0:`CCU_ARB_DEPTH-1];
    logic [`CCU_ARB_DEPTH-1:0]  req_grant;
    logic [`CCU_ARB_DEPTH-1:0]  req_done;
    ccu_pkg::ccu_line_t         req_rdata;
    logic                       bus_req;
    logic                       bus_we;
    ccu_pkg::ccu_addr_t         bus_addr;
    logic [`CCU_BUS_WIDTH-1:0]  bus_wdata;
    ccu_pkg::ccu_len_t          bus_size;
    logic                       bus_ack;
    logic [`CCU_BUS_WIDTH-1:0]  bus_rdata;

    // Expected memory contents that are updated as each write completes
    logic [31:0]                shadow [0:MEM_WORDS-1];
    logic [31:0]                rng;

    ccu_top dut_i (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_len   (req_len),
        .i_req_addr  (req_addr),
        .i_req_wdata (req_wdata),
        .o_req_grant (req_grant),
        .o_req_done  (req_done),
        .o_req_rdata (req_rdata),
        .o_bus_req   (bus_req),
        .o_bus_we    (bus_we),
        .o_bus_addr  (bus_addr),
        .o_bus_wdata (bus_wdata),
        .o_bus_size  (bus_size),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    ccu_mem_model #(
        .WORDS    (MEM_WORDS),
        .FILL_XOR (FILL_XOR),
        .SEED     (SEED)
    ) mem_i (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_bus_req   (bus_req),
        .i_bus_we    (bus_we),
        .i_bus_addr  (bus_addr),
        .i_bus_wdata (bus_wdata),
        .i_bus_size  (bus_size),
        .o_bus_ack   (bus_ack),
        .o_bus_rdata (bus_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int first_index(input logic [`CCU_ARB_DEPTH-1:0] mask);
        int idx;
        idx = 0;
        for (int i = `CCU_ARB_DEPTH - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic [`CCU_ARB_DEPTH-1:0] one_hot(input int r);
        logic [`CCU_ARB_DEPTH-1:0] bits;
        bits    = '0;
        bits[r] = 1'b1;
        return bits;
    endfunction

    // Narrow writes keep the other lanes and take their data from the lanes the address selects
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] data,
                                                input logic [1:0] offset,
                                                input ccu_pkg::ccu_len_t len);
        logic [31:0] word;
        word = old;
        if (len == ccu_pkg::CCU_LEN_BYTE) begin
            word[offset*8 +: 8] = data[offset*8 +: 8];
        end else if (len == ccu_pkg::CCU_LEN_HALF) begin
            word[offset[1]*16 +: 16] = data[offset[1]*16 +: 16];
        end else begin
            word = data;
        end
        return word;
    endfunction

    // A line read returns the aligned line and a shorter read the addressed word in the low bits
    function automatic ccu_pkg::ccu_line_t expected_read(input ccu_pkg::ccu_len_t len,
                                                         input ccu_pkg::ccu_addr_t addr);
        ccu_pkg::ccu_line_t line;
        line = '0;
        if (len == ccu_pkg::CCU_LEN_LINE) begin
            for (int k = 0; k < `CCU_BEATS; k++) begin
                line[k*32 +: 32] = shadow[{addr[9:4], 2'(k)}];
            end
        end else begin
            line[31:0] = shadow[addr[9:2]];
        end
        return line;
    endfunction

    task automatic apply_write(input ccu_pkg::ccu_len_t len, input ccu_pkg::ccu_addr_t addr,
                               input ccu_pkg::ccu_line_t wdata);
        if (len == ccu_pkg::CCU_LEN_LINE) begin
            for (int k = 0; k < `CCU_BEATS; k++) begin
                shadow[{addr[9:4], 2'(k)}] = wdata[k*32 +: 32];
            end
        end else begin
            shadow[addr[9:2]] = merge_write(shadow[addr[9:2]], wdata[31:0], addr[1:0], len);
        end
    endtask

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input ccu_pkg::ccu_line_t got,
                               input ccu_pkg::ccu_line_t exp);
        assert (got === exp)
        else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic drive_request(input int r, input logic we, input ccu_pkg::ccu_len_t len,
                                 input ccu_pkg::ccu_addr_t addr,
                                 input ccu_pkg::ccu_line_t wdata);
        req_we[r]    = we;
        req_len[r]   = len;
        req_addr[r]  = addr;
        req_wdata[r] = wdata;
        req_valid[r] = 1'b1;
    endtask

    // Waits until every requestor in the mask has seen done. The lowest pending index must be
    // the one granted and completed, and valid drops on the falling edge after its done
    task automatic serve_requests(input logic [`CCU_ARB_DEPTH-1:0] mask);
        logic [`CCU_ARB_DEPTH-1:0] pending;
        logic [`CCU_ARB_DEPTH-1:0] granted;
        ccu_pkg::ccu_line_t        exp;
        ccu_pkg::ccu_len_t         exp_size;
        int                        cycles;
        int                        r;
        pending = mask;
        granted = '0;
        cycles  = 0;
        while (pending != '0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: no o_req_done within %0d cycles, pending %b", TIMEOUT, pending);
                stop_with_failure();
            end
            r = first_index(pending);
            // A line moves as word beats and shorter requests keep their own size
            if (bus_req) begin
                if (req_len[r] == ccu_pkg::CCU_LEN_LINE) begin
                    exp_size = ccu_pkg::CCU_LEN_WORD;
                end else begin
                    exp_size = req_len[r];
                end
                check_equal("o_bus_size", ccu_pkg::ccu_line_t'(bus_size),
                            ccu_pkg::ccu_line_t'(exp_size));
                check_equal("o_bus_we", ccu_pkg::ccu_line_t'(bus_we),
                            ccu_pkg::ccu_line_t'(req_we[r]));
            end
            if (req_grant != '0) begin
                check_equal("o_req_grant", ccu_pkg::ccu_line_t'(req_grant),
                            ccu_pkg::ccu_line_t'(one_hot(r)));
                granted = granted | req_grant;
            end
            if (req_done != '0) begin
                check_equal("o_req_done", ccu_pkg::ccu_line_t'(req_done),
                            ccu_pkg::ccu_line_t'(one_hot(r)));
                assert (granted[r])
                else begin
                    $display("Requestor %0d saw done without ever being granted", r);
                    stop_with_failure();
                end
                exp = expected_read(req_len[r], req_addr[r]);
                if (req_we[r]) begin
                    apply_write(req_len[r], req_addr[r], req_wdata[r]);
                end else if (req_len[r] == ccu_pkg::CCU_LEN_LINE) begin
                    check_equal("o_req_rdata", req_rdata, exp);
                end else begin
                    check_equal("o_req_rdata[31:0]", ccu_pkg::ccu_line_t'(req_rdata[31:0]), exp);
                end
                req_valid[r] = 1'b0;
                pending[r]   = 1'b0;
            end
        end
        @(negedge clk);
        check_equal("o_req_done", ccu_pkg::ccu_line_t'(req_done), '0);
    endtask

    task automatic idle_after_reset();
        repeat (8) begin
            @(negedge clk);
            check_equal("o_req_grant", ccu_pkg::ccu_line_t'(req_grant), '0);
            check_equal("o_req_done", ccu_pkg::ccu_line_t'(req_done), '0);
            check_equal("o_bus_req", ccu_pkg::ccu_line_t'(bus_req), '0);
        end
    endtask

    task automatic read_preloaded_line();
        @(negedge clk);
        drive_request(0, 1'b0, ccu_pkg::CCU_LEN_LINE, 32'h0000_0138, '0);
        serve_requests(2'b01);
    endtask

    task automatic write_then_read_back();
        ccu_pkg::ccu_line_t line;
        line = {32'hdead_0003, 32'hbeef_0002, 32'h0bad_0001, 32'hf00d_0000};
        @(negedge clk);
        drive_request(1, 1'b1, ccu_pkg::CCU_LEN_LINE, 32'h0000_0240, line);
        serve_requests(2'b10);
        @(negedge clk);
        drive_request(1, 1'b0, ccu_pkg::CCU_LEN_LINE, 32'h0000_0240, '0);
        serve_requests(2'b10);
        // The word is word 2 of its line so the address is not line aligned
        @(negedge clk);
        drive_request(0, 1'b1, ccu_pkg::CCU_LEN_WORD, 32'h0000_00c8,
                      ccu_pkg::ccu_line_t'(32'h1234_5678));
        serve_requests(2'b01);
        @(negedge clk);
        drive_request(1, 1'b0, ccu_pkg::CCU_LEN_WORD, 32'h0000_00c8, '0);
        serve_requests(2'b10);
    endtask

    task automatic concurrent_requests();
        @(negedge clk);
        drive_request(0, 1'b0, ccu_pkg::CCU_LEN_LINE, 32'h0000_0300, '0);
        drive_request(1, 1'b0, ccu_pkg::CCU_LEN_WORD, 32'h0000_0244, '0);
        serve_requests(2'b11);
        // Requestor 1 reads the word that requestor 0 writes, so it must see the new value
        @(negedge clk);
        drive_request(0, 1'b1, ccu_pkg::CCU_LEN_WORD, 32'h0000_0250,
                      ccu_pkg::ccu_line_t'(32'h5a5a_c3c3));
        drive_request(1, 1'b0, ccu_pkg::CCU_LEN_WORD, 32'h0000_0250, '0);
        serve_requests(2'b11);
    endtask

    task automatic random_traffic();
        int                 r;
        logic               we;
        ccu_pkg::ccu_len_t  len;
        ccu_pkg::ccu_addr_t addr;
        ccu_pkg::ccu_line_t wdata;
        for (int n = 0; n < 20; n++) begin
            rng  = xorshift32(rng);
            r    = int'(rng[0]);
            we   = rng[1];
            len  = ccu_pkg::ccu_len_t'(rng[3:2]);
            // Addresses stay within four lines so reads often land on earlier writes
            addr = 32'h0000_0200 + 32'(rng[9:4]);
            if (len == ccu_pkg::CCU_LEN_HALF) begin
                addr[0] = 1'b0;
            end else if (len == ccu_pkg::CCU_LEN_WORD) begin
                addr[1:0] = 2'b00;
            end
            for (int k = 0; k < `CCU_BEATS; k++) begin
                rng              = xorshift32(rng);
                wdata[k*32 +: 32] = rng;
            end
            @(negedge clk);
            drive_request(r, we, len, addr, wdata);
            serve_requests(one_hot(r));
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = '0;
        req_we    = '0;
        for (int r = 0; r < `CCU_ARB_DEPTH; r++) begin
            req_len[r]   = ccu_pkg::CCU_LEN_WORD;
            req_addr[r]  = '0;
            req_wdata[r] = '0;
        end
        rng = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = FILL_XOR ^ 32'(i);
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        idle_after_reset();
        read_preloaded_line();
        write_then_read_back();
        concurrent_requests();
        random_traffic();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ccu_top.f ====
+incdir+include
source/ccu_pkg.sv
source/ccu_biu_if.sv
source/ccu_arb.sv
source/ccu_biu.sv
source/ccu_top.sv
bench/ccu_mem_model.sv
bench/ccu_tb.sv

// ==== include/ccu_params.svh ====
// Width and size macros for the CCU, included by every file that sizes an address, a line or a bus

`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// Byte address width on both the requestor side and the external bus
`define CCU_ADDR_WIDTH 32

// Cache line size in bytes and in bits
`define CCU_LINE_SIZE 16
`define CCU_LINE_WIDTH (`CCU_LINE_SIZE * 8)

// Number of requestors sharing the BIU
`define CCU_ARB_DEPTH 2

// External bus word width and the number of words in one line
`define CCU_BUS_WIDTH 32
`define CCU_BEATS (`CCU_LINE_WIDTH / `CCU_BUS_WIDTH)

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the CCU testbench with Verilator and runs it, the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps --top-module ccu_tb -f ccu_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit "$status"
fi

./obj_dir/Vccu_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

// ==== source/ccu_arb.sv ====
// Fixed-priority arbiter that picks one requestor and runs its transaction through the BIU

`default_nettype none
`timescale 1ns/10ps

`include "ccu_params.svh"

module ccu_arb (
    input  logic                        i_clk,
    input  logic                        i_arst_n,

    // Requestor side, fields are held with valid until done
    input  logic [`CCU_ARB_DEPTH-1:0]   i_req_valid,
    input  logic [`CCU_ARB_DEPTH-1:0]   i_req_we,
    input  ccu_pkg::ccu_len_t           i_req_len [0:`CCU_ARB_DEPTH-1],
    input  ccu_pkg::ccu_addr_t          i_req_addr [0:`CCU_ARB_DEPTH-1],
    input  ccu_pkg::ccu_line_t          i_req_wdata [0:`CCU_ARB_DEPTH-1],
    output logic [`CCU_ARB_DEPTH-1:0]   o_req_grant,
    output logic [`CCU_ARB_DEPTH-1:0]   o_req_done,
    output ccu_pkg::ccu_line_t          o_req_rdata,

    ccu_biu_if.arb                      biu
);

    localparam int IDX_WIDTH = (`CCU_ARB_DEPTH == 1) ? 1 : $clog2(`CCU_ARB_DEPTH);

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_t;

    arb_state_t             state_r;
    logic [`CCU_ARB_DEPTH-1:0] select;
    logic [IDX_WIDTH-1:0]   idx;
    logic [IDX_WIDTH-1:0]   idx_r;
    logic                   en_r;
    ccu_pkg::ccu_biu_func_t func_r;
    ccu_pkg::ccu_len_t      len_r;
    ccu_pkg::ccu_addr_t     addr_r;
    ccu_pkg::ccu_line_t     wdata_r;

    // Isolate the lowest set valid bit, so requestor 0 always wins
    assign select = i_req_valid & (~i_req_valid + 1'b1);

    // One-hot pick to a mux index
    always_comb begin
        idx = '0;
        for (int i = 0; i < `CCU_ARB_DEPTH; i++) begin
            if (select[i]) begin
                idx = IDX_WIDTH'(i);
            end
        end
    end

    // IDLE grants and latches the index, BUSY holds en until the BIU
    // reports done, DONE gives the requestor one cycle to drop valid
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r     <= ARB_IDLE;
            idx_r       <= '0;
            en_r        <= 1'b0;
            o_req_grant <= '0;
            o_req_done  <= '0;
        end else begin
            o_req_grant <= '0;
            o_req_done  <= '0;
            unique case (state_r)
                ARB_IDLE: begin
                    idx_r <= idx;
                    if (select != '0) begin
                        o_req_grant <= select;
                        state_r     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (biu.done) begin
                        o_req_done[idx_r] <= 1'b1;
                        en_r              <= 1'b0;
                        state_r           <= ARB_DONE;
                    end else begin
                        en_r <= 1'b1;
                    end
                end
                ARB_DONE: state_r <= ARB_IDLE;
                default:  state_r <= ARB_IDLE;
            endcase
        end
    end

    // Request fields follow the held requestor while the transaction runs
    always_ff @(posedge i_clk) begin
        if (state_r == ARB_BUSY) begin
            func_r  <= i_req_we[idx_r] ? ccu_pkg::CCU_BIU_FUNC_WRITE
                                       : ccu_pkg::CCU_BIU_FUNC_READ;
            len_r   <= i_req_len[idx_r];
            addr_r  <= i_req_addr[idx_r];
            wdata_r <= i_req_wdata[idx_r];
            if (biu.done) begin
                o_req_rdata <= biu.rdata;
            end
        end
    end

    assign biu.en    = en_r;
    assign biu.func  = func_r;
    assign biu.len   = len_r;
    assign biu.addr  = addr_r;
    assign biu.wdata = wdata_r;

endmodule

`default_nettype wire

// ==== source/ccu_biu.sv ====
// Bus interface unit that splits a CCU transaction into word beats on the external memory bus

`default_nettype none
`timescale 1ns/10ps

`include "ccu_params.svh"

module ccu_biu (
    input  logic                        i_clk,
    input  logic                        i_arst_n,

    ccu_biu_if.biu                      arb,

    // External memory bus
    output logic                        o_bus_req,
    output logic                        o_bus_we,
    output ccu_pkg::ccu_addr_t          o_bus_addr,
    output logic [`CCU_BUS_WIDTH-1:0]   o_bus_wdata,
    output ccu_pkg::ccu_len_t           o_bus_size,
    input  logic                        i_bus_ack,
    input  logic [`CCU_BUS_WIDTH-1:0]   i_bus_rdata
);

    localparam int CNT_WIDTH    = $clog2(`CCU_BEATS);
    localparam int OFFSET_WIDTH = $clog2(`CCU_LINE_SIZE);
    localparam int WORD_BYTES   = `CCU_BUS_WIDTH / 8;

    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_BEAT = 2'b01,
        BIU_DONE = 2'b10
    } biu_state_t;

    biu_state_t             state_r;
    logic [CNT_WIDTH-1:0]   beat_r;
    logic [CNT_WIDTH-1:0]   last_r;
    logic [CNT_WIDTH-1:0]   beat_next;
    logic                   is_line;
    logic                   start;
    ccu_pkg::ccu_line_t     line_r;

    assign is_line   = (arb.len == ccu_pkg::CCU_LEN_LINE);
    assign start     = (state_r == BIU_IDLE) && arb.en;
    assign beat_next = beat_r + 1'b1;

    // A beat ends on the edge where req and ack are both high,
    // req stays up between beats of the same line
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r   <= BIU_IDLE;
            beat_r    <= '0;
            last_r    <= '0;
            o_bus_req <= 1'b0;
        end else begin
            unique case (state_r)
                BIU_IDLE: begin
                    if (arb.en) begin
                        beat_r    <= '0;
                        last_r    <= is_line ? CNT_WIDTH'(`CCU_BEATS - 1) : '0;
                        o_bus_req <= 1'b1;
                        state_r   <= BIU_BEAT;
                    end
                end
                BIU_BEAT: begin
                    if (i_bus_ack) begin
                        if (beat_r == last_r) begin
                            o_bus_req <= 1'b0;
                            state_r   <= BIU_DONE;
                        end else begin
                            beat_r <= beat_next;
                        end
                    end
                end
                BIU_DONE: state_r <= BIU_IDLE;
                default:  state_r <= BIU_IDLE;
            endcase
        end
    end

    // Line transfers start at the aligned address and move one word per beat
    always_ff @(posedge i_clk) begin
        if (start) begin
            o_bus_we    <= (arb.func == ccu_pkg::CCU_BIU_FUNC_WRITE);
            o_bus_size  <= is_line ? ccu_pkg::CCU_LEN_WORD : arb.len;
            o_bus_addr  <= is_line ? {arb.addr[`CCU_ADDR_WIDTH-1:OFFSET_WIDTH], OFFSET_WIDTH'(0)}
                                   : arb.addr;
            o_bus_wdata <= arb.wdata[0 +: `CCU_BUS_WIDTH];
        end else if ((state_r == BIU_BEAT) && i_bus_ack) begin
            line_r[beat_r * `CCU_BUS_WIDTH +: `CCU_BUS_WIDTH] <= i_bus_rdata;
            o_bus_addr  <= o_bus_addr + ccu_pkg::ccu_addr_t'(WORD_BYTES);
            o_bus_wdata <= arb.wdata[beat_next * `CCU_BUS_WIDTH +: `CCU_BUS_WIDTH];
        end
    end

    // Done follows the last ack by one cycle and carries the assembled line
    assign arb.done  = (state_r == BIU_DONE);
    assign arb.rdata = line_r;

endmodule

`default_nettype wire

// ==== source/ccu_biu_if.sv ====
// Request and completion signals between the CCU arbiter and the BIU, with one modport per side

`default_nettype none
`timescale 1ns/10ps

interface ccu_biu_if;

    // Request side, en is a level held until the cycle after done
    logic                   en;
    ccu_pkg::ccu_biu_func_t func;
    ccu_pkg::ccu_len_t      len;
    ccu_pkg::ccu_addr_t     addr;
    ccu_pkg::ccu_line_t     wdata;

    // Completion side, done is a single-cycle pulse and rdata is valid with it
    logic                   done;
    ccu_pkg::ccu_line_t     rdata;

    modport arb (
        output en, func, len, addr, wdata,
        input  done, rdata
    );

    modport biu (
        input  en, func, len, addr, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== source/ccu_pkg.sv ====
// Shared CCU types for request length, BIU function, lines and addresses, referenced by scoped names

`default_nettype none

`include "ccu_params.svh"

package ccu_pkg;

    // Size of one request, LINE moves a whole cache line in several bus beats
    typedef enum logic [1:0] {
        CCU_LEN_BYTE = 2'b00,
        CCU_LEN_HALF = 2'b01,
        CCU_LEN_WORD = 2'b10,
        CCU_LEN_LINE = 2'b11
    } ccu_len_t;

    // Direction of a BIU transaction
    typedef enum logic {
        CCU_BIU_FUNC_READ  = 1'b0,
        CCU_BIU_FUNC_WRITE = 1'b1
    } ccu_biu_func_t;

    // One cache line of data, word 0 in the low bits
    typedef logic [`CCU_LINE_WIDTH-1:0] ccu_line_t;

    // One byte address
    typedef logic [`CCU_ADDR_WIDTH-1:0] ccu_addr_t;

endpackage

`default_nettype wire

// ==== source/ccu_top.sv ====
// CCU top level joining the requestor arbiter and the BIU, with plain requestor and bus ports

`default_nettype none
`timescale 1ns/10ps

`include "ccu_params.svh"

module ccu_top (
    input  logic                        i_clk,
    input  logic                        i_arst_n,

    // Requestors
    input  logic [`CCU_ARB_DEPTH-1:0]   i_req_valid,
    input  logic [`CCU_ARB_DEPTH-1:0]   i_req_we,
    input  ccu_pkg::ccu_len_t           i_req_len [0:`CCU_ARB_DEPTH-1],
    input  ccu_pkg::ccu_addr_t          i_req_addr [0:`CCU_ARB_DEPTH-1],
    input  ccu_pkg::ccu_line_t          i_req_wdata [0:`CCU_ARB_DEPTH-1],
    output logic [`CCU_ARB_DEPTH-1:0]   o_req_grant,
    output logic [`CCU_ARB_DEPTH-1:0]   o_req_done,
    output ccu_pkg::ccu_line_t          o_req_rdata,

    // External memory bus
    output logic                        o_bus_req,
    output logic                        o_bus_we,
    output ccu_pkg::ccu_addr_t          o_bus_addr,
    output logic [`CCU_BUS_WIDTH-1:0]   o_bus_wdata,
    output ccu_pkg::ccu_len_t           o_bus_size,
    input  logic                        i_bus_ack,
    input  logic [`CCU_BUS_WIDTH-1:0]   i_bus_rdata
);

    ccu_biu_if biu_bus ();

    ccu_arb arb_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req_valid (i_req_valid),
        .i_req_we    (i_req_we),
        .i_req_len   (i_req_len),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_req_grant (o_req_grant),
        .o_req_done  (o_req_done),
        .o_req_rdata (o_req_rdata),
        .biu         (biu_bus.arb)
    );

    ccu_biu biu_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .arb         (biu_bus.biu),
        .o_bus_req   (o_bus_req),
        .o_bus_we    (o_bus_we),
        .o_bus_addr  (o_bus_addr),
        .o_bus_wdata (o_bus_wdata),
        .o_bus_size  (o_bus_size),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata)
    );

endmodule

`default_nettype wire
